//--- branch_recovery_unit.f
+incdir+include
rtl/branch_pkg.sv
rtl/branch_tag_alloc.sv
rtl/branch_stack.sv
rtl/resolve_select.sv
rtl/branch_recovery_unit.sv
verif/branch_recovery_unit_asserts.sv
verif/branch_recovery_unit_tb.sv

//--- include/branch_defs.svh
`ifndef BRANCH_DEFS_SVH
`define BRANCH_DEFS_SVH

// Checkpoint slots, one tag bit per slot
`define BS_DEPTH 4

// Program counter width
`define ADDR_BITS 32

// ROB tail pointer width
`define ROB_PTR_BITS 5

// Free list holds one bit per physical register
`define PHYS_REGS 32
`define PHYS_IDX_BITS 5

// Architectural registers held in the map table
`define ARCH_REGS 8

`endif

//--- rtl/branch_pkg.sv
`default_nettype none

`include "branch_defs.svh"

package branch_pkg;

    // One-hot it names a single branch, otherwise a set of branches
    typedef logic [`BS_DEPTH-1:0] b_mask_t;

    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [`ROB_PTR_BITS-1:0] rob_ptr_t;
    typedef logic [`PHYS_REGS-1:0] free_list_t;
    typedef logic [`PHYS_IDX_BITS-1:0] phys_idx_t;

    // Arch register to physical register mapping
    typedef phys_idx_t [`ARCH_REGS-1:0] map_table_t;

    // One saved checkpoint
    // recovery_pc is the not-predicted path for a branch, the predicted target for a jump
    typedef struct packed {
        logic       valid;
        logic       is_jump;
        b_mask_t    older_mask;
        addr_t      branch_pc;
        addr_t      recovery_pc;
        rob_ptr_t   rob_tail;
        map_table_t map_table;
        free_list_t free_list;
    } bs_entry_t;

endpackage

`default_nettype wire

//--- rtl/branch_recovery_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defs.svh"

module branch_recovery_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  logic                   dispatch_is_jump,
    input  branch_pkg::addr_t      dispatch_pc,
    input  branch_pkg::addr_t      dispatch_recovery_pc,
    input  branch_pkg::rob_ptr_t   dispatch_rob_tail,
    input  branch_pkg::map_table_t dispatch_map_table,
    input  branch_pkg::free_list_t dispatch_free_list,
    input  logic                   complete_valid,
    input  branch_pkg::b_mask_t    complete_tag,
    input  logic                   complete_mispredict,
    input  logic                   complete_predict_taken,
    input  branch_pkg::addr_t      complete_target_pc,
    input  branch_pkg::free_list_t retire_free,
    output logic                   stack_full,
    output branch_pkg::b_mask_t    dispatch_tag,
    output branch_pkg::b_mask_t    active_mask,
    output logic                   resolve_valid,
    output branch_pkg::b_mask_t    resolve_tag,
    output logic                   resolve_is_branch,
    output branch_pkg::addr_t      resolve_branch_pc,
    output logic                   restore_valid,
    output branch_pkg::addr_t      restore_pc,
    output branch_pkg::rob_ptr_t   restore_rob_tail,
    output branch_pkg::map_table_t restore_map_table,
    output branch_pkg::free_list_t restore_free_list
);
    import branch_pkg::*;

    b_mask_t                   alloc_tag;
    b_mask_t                   release_mask;
    bs_entry_t [`BS_DEPTH-1:0] stack_entries;

    // Slot being written is the tag handed back to dispatch
    assign dispatch_tag = alloc_tag;

    branch_tag_alloc u_tag_alloc (
        .clock         (clock),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .restore_valid (restore_valid),
        .release_mask  (release_mask),
        .alloc_tag     (alloc_tag),
        .active_mask   (active_mask),
        .stack_full    (stack_full)
    );

    branch_stack u_stack (
        .clock               (clock),
        .reset               (reset),
        .alloc_tag           (alloc_tag),
        .active_mask         (active_mask),
        .release_mask        (release_mask),
        .resolve_tag         (resolve_tag),
        .dispatch_is_jump    (dispatch_is_jump),
        .dispatch_pc         (dispatch_pc),
        .dispatch_recovery_pc(dispatch_recovery_pc),
        .dispatch_rob_tail   (dispatch_rob_tail),
        .dispatch_map_table  (dispatch_map_table),
        .dispatch_free_list  (dispatch_free_list),
        .retire_free         (retire_free),
        .stack_entries       (stack_entries)
    );

    resolve_select u_resolve (
        .complete_valid        (complete_valid),
        .complete_tag          (complete_tag),
        .complete_mispredict   (complete_mispredict),
        .complete_predict_taken(complete_predict_taken),
        .complete_target_pc    (complete_target_pc),
        .active_mask           (active_mask),
        .stack_entries         (stack_entries),
        .resolve_valid         (resolve_valid),
        .resolve_is_branch     (resolve_is_branch),
        .resolve_tag           (resolve_tag),
        .resolve_branch_pc     (resolve_branch_pc),
        .restore_valid         (restore_valid),
        .restore_pc            (restore_pc),
        .restore_rob_tail      (restore_rob_tail),
        .restore_map_table     (restore_map_table),
        .restore_free_list     (restore_free_list),
        .release_mask          (release_mask)
    );

endmodule

`default_nettype wire

//--- rtl/branch_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defs.svh"

module branch_stack (
    input  logic                                  clock,
    input  logic                                  reset,
    input  branch_pkg::b_mask_t                   alloc_tag,
    input  branch_pkg::b_mask_t                   active_mask,
    input  branch_pkg::b_mask_t                   release_mask,
    input  branch_pkg::b_mask_t                   resolve_tag,
    input  logic                                  dispatch_is_jump,
    input  branch_pkg::addr_t                     dispatch_pc,
    input  branch_pkg::addr_t                     dispatch_recovery_pc,
    input  branch_pkg::rob_ptr_t                  dispatch_rob_tail,
    input  branch_pkg::map_table_t                dispatch_map_table,
    input  branch_pkg::free_list_t                dispatch_free_list,
    input  branch_pkg::free_list_t                retire_free,
    output branch_pkg::bs_entry_t [`BS_DEPTH-1:0] stack_entries
);
    import branch_pkg::*;

    bs_entry_t [`BS_DEPTH-1:0] entries;
    bs_entry_t [`BS_DEPTH-1:0] next_entries;
    b_mask_t                   new_older_mask;

    // Branches still unresolved after this cycle are older than the new one
    assign new_older_mask = active_mask & ~release_mask;

    always_comb begin
        next_entries = entries;
        for (int i = 0; i < `BS_DEPTH; i++) begin
            if (release_mask[i]) begin
                // Payload is left in place, only the control bits drop
                next_entries[i].valid = 1'b0;
                next_entries[i].older_mask = '0;
            end else if (entries[i].valid) begin
                // Resolved branch is no longer a dependency
                next_entries[i].older_mask = entries[i].older_mask & ~resolve_tag;
                // Registers retired after the checkpoint are free on recovery too
                next_entries[i].free_list = entries[i].free_list | retire_free;
            end

            if (alloc_tag[i]) begin
                next_entries[i].valid = 1'b1;
                next_entries[i].is_jump = dispatch_is_jump;
                next_entries[i].older_mask = new_older_mask;
                next_entries[i].branch_pc = dispatch_pc;
                next_entries[i].recovery_pc = dispatch_recovery_pc;
                next_entries[i].rob_tail = dispatch_rob_tail;
                next_entries[i].map_table = dispatch_map_table;
                next_entries[i].free_list = dispatch_free_list;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `BS_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].older_mask <= '0;
            end
        end else begin
            entries <= next_entries;
        end
    end

    assign stack_entries = entries;

endmodule

`default_nettype wire

//--- rtl/branch_tag_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defs.svh"

module branch_tag_alloc (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  logic                restore_valid,
    input  branch_pkg::b_mask_t release_mask,
    output branch_pkg::b_mask_t alloc_tag,
    output branch_pkg::b_mask_t active_mask,
    output logic                stack_full
);
    import branch_pkg::*;

    b_mask_t free_slot;
    logic    accept;

    // Every slot holds an unresolved branch
    assign stack_full = &active_mask;

    // A branch seen in a restore cycle is on the squashed path
    assign accept = dispatch_valid && !stack_full && !restore_valid;

    // Priority search, lowest clear bit wins
    always_comb begin
        free_slot = '0;
        for (int i = `BS_DEPTH - 1; i >= 0; i--) begin
            if (!active_mask[i]) begin
                free_slot = '0;
                free_slot[i] = 1'b1;
            end
        end
    end

    // Zero when nothing is written this cycle
    assign alloc_tag = accept ? free_slot : '0;

    // Released slots become free at the edge, so they are reusable one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            active_mask <= '0;
        end else begin
            active_mask <= (active_mask & ~release_mask) | alloc_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/resolve_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defs.svh"

module resolve_select (
    input  logic                                  complete_valid,
    input  branch_pkg::b_mask_t                   complete_tag,
    input  logic                                  complete_mispredict,
    input  logic                                  complete_predict_taken,
    input  branch_pkg::addr_t                     complete_target_pc,
    input  branch_pkg::b_mask_t                   active_mask,
    input  branch_pkg::bs_entry_t [`BS_DEPTH-1:0] stack_entries,
    output logic                                  resolve_valid,
    output logic                                  resolve_is_branch,
    output branch_pkg::b_mask_t                   resolve_tag,
    output branch_pkg::addr_t                     resolve_branch_pc,
    output logic                                  restore_valid,
    output branch_pkg::addr_t                     restore_pc,
    output branch_pkg::rob_ptr_t                  restore_rob_tail,
    output branch_pkg::map_table_t                restore_map_table,
    output branch_pkg::free_list_t                restore_free_list,
    output branch_pkg::b_mask_t                   release_mask
);
    import branch_pkg::*;

    b_mask_t   hit;
    b_mask_t   younger;
    bs_entry_t sel;
    logic      target_mismatch;

    // Completions for slots that are not live are ignored
    assign hit = complete_valid ? (complete_tag & active_mask) : '0;

    assign resolve_valid = |hit;
    assign resolve_tag = hit;

    // Checkpoint mux on the one-hot tag
    always_comb begin
        sel = '0;
        for (int i = 0; i < `BS_DEPTH; i++) begin
            if (hit[i]) begin
                sel = stack_entries[i];
            end
        end
    end

    // A jump saved its predicted target in recovery_pc
    assign target_mismatch = sel.is_jump && (complete_target_pc != sel.recovery_pc);

    assign restore_valid = resolve_valid && (complete_mispredict || target_mismatch);

    assign resolve_is_branch = resolve_valid && !sel.is_jump;
    assign resolve_branch_pc = sel.branch_pc;

    // Taken-predicted branch restarts on the fall-through held in recovery_pc
    always_comb begin
        restore_pc = '0;
        restore_rob_tail = '0;
        restore_map_table = '0;
        restore_free_list = '0;
        if (restore_valid) begin
            if (!sel.is_jump && complete_predict_taken) begin
                restore_pc = sel.recovery_pc;
            end else begin
                restore_pc = complete_target_pc;
            end
            restore_rob_tail = sel.rob_tail;
            restore_map_table = sel.map_table;
            restore_free_list = sel.free_list;
        end
    end

    // Checkpoints taken after the resolving branch
    always_comb begin
        younger = '0;
        for (int i = 0; i < `BS_DEPTH; i++) begin
            younger[i] = stack_entries[i].valid && active_mask[i]
                         && |(stack_entries[i].older_mask & hit);
        end
    end

    assign release_mask = hit | (restore_valid ? younger : '0);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module branch_recovery_unit_tb \
    -f branch_recovery_unit.f -o sim_tb || exit 1
output=$(./obj_dir/sim_tb)
echo "$output"
echo "$output" | grep -q "^Simulation passed$" && echo "Run OK" || { echo "Run FAILED"; exit 1; }

//--- verif/branch_recovery_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module branch_recovery_unit_asserts (
    input logic                clock,
    input logic                reset,
    input branch_pkg::b_mask_t dispatch_tag,
    input branch_pkg::b_mask_t active_mask,
    input logic                stack_full,
    input logic                resolve_valid,
    input branch_pkg::b_mask_t resolve_tag,
    input logic                restore_valid
);

    // Failed assertions so far
    int fail_count = 0;

    // A dispatch gets at most one slot
    tag_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(dispatch_tag))
        else begin
            fail_count++;
            $error("dispatch_tag has more than one bit set");
        end

    // Restore only comes with a resolution
    restore_needs_resolve: assert property (@(posedge clock) disable iff (reset)
        restore_valid |-> resolve_valid)
        else begin
            fail_count++;
            $error("restore_valid without resolve_valid");
        end

    full_when_all_active: assert property (@(posedge clock) disable iff (reset)
        stack_full |-> (&active_mask))
        else begin
            fail_count++;
            $error("stack_full while a slot is free");
        end

    // Only live branches can resolve
    resolve_is_active: assert property (@(posedge clock) disable iff (reset)
        (resolve_tag & ~active_mask) == '0)
        else begin
            fail_count++;
            $error("resolve_tag names an inactive slot");
        end

endmodule

bind branch_recovery_unit branch_recovery_unit_asserts u_asserts (
    .clock        (clock),
    .reset        (reset),
    .dispatch_tag (dispatch_tag),
    .active_mask  (active_mask),
    .stack_full   (stack_full),
    .resolve_valid(resolve_valid),
    .resolve_tag  (resolve_tag),
    .restore_valid(restore_valid)
);

`default_nettype wire

//--- verif/branch_recovery_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defs.svh"

module branch_recovery_unit_tb;
    import branch_pkg::*;

    localparam int NUM_CYCLES = 2000;
    // Random run plus reset and a margin
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;

    logic       clock;
    logic       reset;
    logic       dispatch_valid;
    logic       dispatch_is_jump;
    addr_t      dispatch_pc;
    addr_t      dispatch_recovery_pc;
    rob_ptr_t   dispatch_rob_tail;
    map_table_t dispatch_map_table;
    free_list_t dispatch_free_list;
    logic       complete_valid;
    b_mask_t    complete_tag;
    logic       complete_mispredict;
    logic       complete_predict_taken;
    addr_t      complete_target_pc;
    free_list_t retire_free;
    logic       stack_full;
    b_mask_t    dispatch_tag;
    b_mask_t    active_mask;
    logic       resolve_valid;
    b_mask_t    resolve_tag;
    logic       resolve_is_branch;
    addr_t      resolve_branch_pc;
    logic       restore_valid;
    addr_t      restore_pc;
    rob_ptr_t   restore_rob_tail;
    map_table_t restore_map_table;
    free_list_t restore_free_list;

    // Reference model state and this cycle's prediction
    b_mask_t    m_active;
    bs_entry_t  m_slot [`BS_DEPTH];
    bs_entry_t  exp_sel;
    b_mask_t    exp_hit;
    b_mask_t    exp_release;
    b_mask_t    exp_alloc;
    logic       exp_restore;
    addr_t      exp_restore_pc;
    logic [31:0] lfsr;
    int         cycle_count = 0;

    branch_recovery_unit uut (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic compare_mask(input string name, input b_mask_t expected, input b_mask_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %0t: %s expected %h, actual %h", $time, name, expected, actual));
        end
    endtask

    task automatic compare_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %0t: %s expected %h, actual %h", $time, name, expected, actual));
        end
    endtask

    task automatic compare_rob(input string name, input rob_ptr_t expected, input rob_ptr_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %0t: %s expected %h, actual %h", $time, name, expected, actual));
        end
    endtask

    task automatic compare_map(input string name, input map_table_t expected,
                               input map_table_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %0t: %s expected %h, actual %h", $time, name, expected, actual));
        end
    endtask

    task automatic compare_free(input string name, input free_list_t expected,
                                input free_list_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %0t: %s expected %h, actual %h", $time, name, expected, actual));
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %0t: %s expected %b, actual %b", $time, name, expected, actual));
        end
    endtask

    // Fill phases dispatch hard, drain phases complete hard
    task automatic drive_inputs(input int cycle);
        logic fill_phase;
        int   idx;
        int   pick;
        fill_phase = (cycle % 200) < 100;
        dispatch_valid = fill_phase ? (random_bits(3) != 0) : (random_bits(2) == 0);
        dispatch_is_jump = random_bits(2) == 0;
        dispatch_pc = random_bits(32);
        dispatch_recovery_pc = random_bits(32);
        dispatch_rob_tail = rob_ptr_t'(random_bits(5));
        dispatch_map_table = map_table_t'({random_bits(8), random_bits(32)});
        dispatch_free_list = random_bits(32);
        complete_valid = fill_phase ? (random_bits(2) == 0) : (random_bits(2) != 0);
        idx = int'(random_bits(2));
        pick = idx;
        // Mostly aim at a live slot
        if (random_bits(2) != 0) begin
            for (int k = `BS_DEPTH - 1; k >= 0; k--) begin
                if (m_active[(idx + k) % `BS_DEPTH]) begin
                    pick = (idx + k) % `BS_DEPTH;
                end
            end
        end
        complete_tag = b_mask_t'(1) << pick;
        complete_mispredict = random_bits(3) == 0;
        complete_predict_taken = random_bits(1) != 0;
        complete_target_pc = (random_bits(2) != 0) ? m_slot[pick].recovery_pc : random_bits(32);
        retire_free = (random_bits(2) == 0) ? (random_bits(32) & random_bits(32)) : '0;
    endtask

    task automatic predict_outputs();
        b_mask_t younger;
        logic    found;
        exp_sel = '0;
        younger = '0;
        exp_hit = complete_valid ? (complete_tag & m_active) : '0;
        for (int i = 0; i < `BS_DEPTH; i++) begin
            if (exp_hit[i]) begin
                exp_sel = m_slot[i];
            end
            younger[i] = m_active[i] && ((m_slot[i].older_mask & exp_hit) != '0);
        end
        exp_restore = (|exp_hit) && (complete_mispredict
                      || (exp_sel.is_jump && complete_target_pc != exp_sel.recovery_pc));
        exp_restore_pc = '0;
        if (exp_restore) begin
            exp_restore_pc = (!exp_sel.is_jump && complete_predict_taken)
                             ? exp_sel.recovery_pc : complete_target_pc;
        end
        exp_release = exp_hit | (exp_restore ? younger : '0);
        // Lowest free slot, none when full or restoring
        exp_alloc = '0;
        found = 1'b0;
        for (int i = 0; i < `BS_DEPTH; i++) begin
            if (!found && !m_active[i] && dispatch_valid && !exp_restore) begin
                exp_alloc[i] = 1'b1;
                found = 1'b1;
            end
        end
    endtask

    task automatic compare_outputs();
        compare_flag("stack_full", &m_active, stack_full);
        compare_mask("dispatch_tag", exp_alloc, dispatch_tag);
        compare_mask("active_mask", m_active, active_mask);
        compare_flag("resolve_valid", |exp_hit, resolve_valid);
        compare_mask("resolve_tag", exp_hit, resolve_tag);
        compare_flag("resolve_is_branch", |exp_hit && !exp_sel.is_jump, resolve_is_branch);
        compare_addr("resolve_branch_pc", exp_sel.branch_pc, resolve_branch_pc);
        compare_flag("restore_valid", exp_restore, restore_valid);
        compare_addr("restore_pc", exp_restore_pc, restore_pc);
        compare_rob("restore_rob_tail", exp_restore ? exp_sel.rob_tail : '0, restore_rob_tail);
        compare_map("restore_map_table", exp_restore ? exp_sel.map_table : '0, restore_map_table);
        compare_free("restore_free_list", exp_restore ? exp_sel.free_list : '0,
                     restore_free_list);
    endtask

    task automatic update_model();
        b_mask_t survivors;
        survivors = m_active & ~exp_release;
        for (int i = 0; i < `BS_DEPTH; i++) begin
            if (exp_release[i]) begin
                m_slot[i].valid = 1'b0;
            end else if (m_active[i]) begin
                m_slot[i].older_mask &= ~exp_hit;
                m_slot[i].free_list |= retire_free;
            end
            if (exp_alloc[i]) begin
                m_slot[i] = {1'b1, dispatch_is_jump, survivors, dispatch_pc, dispatch_recovery_pc,
                             dispatch_rob_tail, dispatch_map_table, dispatch_free_list};
            end
        end
        m_active = survivors | exp_alloc;
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the random run did not finish within the cycle limit");
        end
    end

    initial begin
        lfsr = 32'h2717_217d;
        m_active = '0;
        for (int i = 0; i < `BS_DEPTH; i++) begin
            m_slot[i] = '0;
        end
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_is_jump = 1'b0;
        dispatch_pc = '0;
        dispatch_recovery_pc = '0;
        dispatch_rob_tail = '0;
        dispatch_map_table = '0;
        dispatch_free_list = '0;
        complete_valid = 1'b0;
        complete_tag = '0;
        complete_mispredict = 1'b0;
        complete_predict_taken = 1'b0;
        complete_target_pc = '0;
        retire_free = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(negedge clock);
            drive_inputs(cycle);
            // Combinational outputs settle well before the rising edge
            #5;
            predict_outputs();
            compare_outputs();
            @(posedge clock);
            update_model();
        end
        // Let the assertions of the last edge finish
        @(negedge clock);
        if (uut.u_asserts.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            fail_run("An assertion failed during the run");
        end
    end

endmodule

`default_nettype wire
